// ==== filelist.f ====
+incdir+hw
hw/spim_pkg.sv
hw/spim_cmd_decode.sv
hw/spim_cfg_cs.sv
hw/spim_xfer_seq.sv
hw/spim_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_spim_top.sv

// ==== hw/spim_cfg_cs.sv ====
`timescale 1ns/1ns
`include "spim_macros.svh"

module spim_cfg_cs
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  spim_pkg::spim_op_t      op_i,
    input  logic                    op_valid_i,
    output logic                    cfg_taken_o,
    output spim_pkg::spim_cfg_t     cfg_o,
    output logic                    cfg_clkdiv_valid_o,
    input  logic                    cfg_clkdiv_ack_i,
    output logic [`SPIM_NUM_CS-1:0] spi_csn_o,
    output logic                    eot_o
);

    import spim_pkg::*;

    spim_cfg_t               cfg_q;
    logic                    clkdiv_valid_q;
    logic [`SPIM_NUM_CS-1:0] csn_q;
    logic [`SPIM_NUM_CS-1:0] csn_sel;
    logic                    eot_q;
    logic                    take_cfg;
    logic                    take_sot;
    logic                    take_eot;

    // Never stalls, so every owned op goes in the cycle it shows up
    assign cfg_taken_o = op_valid_i && (op_i.cmd inside {CMD_CFG, CMD_SOT, CMD_EOT});
    assign take_cfg    = cfg_taken_o && (op_i.cmd == CMD_CFG);
    assign take_sot    = cfg_taken_o && (op_i.cmd == CMD_SOT);
    assign take_eot    = cfg_taken_o && (op_i.cmd == CMD_EOT);

    // Only the addressed select goes low
    always_comb
    begin
        csn_sel          = '1;
        csn_sel[op_i.cs] = 1'b0;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cfg_q          <= '0;
            clkdiv_valid_q <= 1'b0;
            csn_q          <= '1;
            eot_q          <= 1'b0;
        end
        else
        begin
            if (take_cfg)
                cfg_q <= op_i.cfg;

            // Divider stays offered until the clock generator acks
            if (take_cfg)
                clkdiv_valid_q <= 1'b1;
            else if (cfg_clkdiv_ack_i)
                clkdiv_valid_q <= 1'b0;

            if (take_sot)
                csn_q <= csn_sel;
            else if (take_eot)
                csn_q <= '1;

            eot_q <= take_eot && op_i.eot;
        end
    end

    assign cfg_o              = cfg_q;
    assign cfg_clkdiv_valid_o = clkdiv_valid_q;
    assign spi_csn_o          = csn_q;
    assign eot_o              = eot_q;

    a_one_cs: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(~spi_csn_o));

endmodule

// ==== hw/spim_cmd_decode.sv ====
`timescale 1ns/1ns
`include "spim_macros.svh"

module spim_cmd_decode
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`SPIM_DATA_W-1:0] cmd_data_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    output spim_pkg::spim_op_t      op_o,
    output logic                    op_valid_o,
    input  logic                    cfg_taken_i,
    input  logic                    seq_ready_i
);

    import spim_pkg::*;

    spim_op_t op_d;
    spim_op_t op_q;
    logic     op_valid_q;
    logic     op_known;
    logic     op_load;
    logic     op_taken;
    logic     cfg_owned;

    // Field split of the incoming word
    always_comb
    begin
        op_d            = '0;
        op_d.cmd        = spim_cmd_e'(cmd_data_i[`SPIM_DATA_W-1 -: `SPIM_CMD_W]);
        op_d.qpi        = cmd_data_i[27];
        op_d.custom     = cmd_data_i[26];
        op_d.cfg.cpol   = cmd_data_i[9];
        op_d.cfg.cpha   = cmd_data_i[8];
        op_d.cfg.clkdiv = cmd_data_i[`SPIM_CLKDIV_W-1:0];
        op_d.cs         = cmd_data_i[$clog2(`SPIM_NUM_CS)-1:0];
        op_d.eot        = cmd_data_i[0];
        op_d.cmd_data   = cmd_data_i[`SPIM_DATA_W/2-1:0];
        if (op_d.cmd == CMD_SEND_CMD)
            op_d.size = {{(`SPIM_SIZE_W-5){1'b0}}, cmd_data_i[20:16]};
        else
            op_d.size = cmd_data_i[`SPIM_SIZE_W-1:0];

        case (op_d.cmd)
            CMD_CFG, CMD_SOT, CMD_SEND_CMD, CMD_TX_DATA,
            CMD_RX_DATA, CMD_EOT, CMD_WAIT_CYC:
                op_known = 1'b1;
            default:
                op_known = 1'b0;
        endcase
    end

    assign cfg_owned   = op_q.cmd inside {CMD_CFG, CMD_SOT, CMD_EOT};
    assign op_taken    = op_valid_q && (cfg_owned ? cfg_taken_i : seq_ready_i);
    // Room when empty or draining this cycle
    assign cmd_ready_o = !op_valid_q || op_taken;
    // Unknown opcodes are accepted but never stored
    assign op_load     = cmd_valid_i && cmd_ready_o && op_known;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            op_valid_q <= 1'b0;
        else if (op_load)
            op_valid_q <= 1'b1;
        else if (op_taken)
            op_valid_q <= 1'b0;
    end

    always_ff @(posedge clk_i)
    begin
        if (op_load)
            op_q <= op_d;
    end

    assign op_o       = op_q;
    assign op_valid_o = op_valid_q;

    // A pending op that nobody takes stays put
    a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rstn_i)
        op_valid_q && !op_taken |=> op_valid_q && $stable(op_q));

endmodule

// ==== hw/spim_ctrl_top.sv ====
`timescale 1ns/1ns
`include "spim_macros.svh"

module spim_ctrl_top
(
    input  logic                      clk_i,
    input  logic                      rstn_i,

    input  logic [`SPIM_DATA_W-1:0]   cmd_data_i,
    input  logic                      cmd_valid_i,
    output logic                      cmd_ready_o,

    output spim_pkg::spim_cfg_t       cfg_o,
    output logic                      cfg_clkdiv_valid_o,
    input  logic                      cfg_clkdiv_ack_i,
    output logic [`SPIM_NUM_CS-1:0]   spi_csn_o,
    output logic                      eot_o,

    output spim_pkg::spim_xfer_req_t  tx_req_o,
    output logic                      tx_start_o,
    input  logic                      tx_done_i,
    output logic [`SPIM_DATA_W-1:0]   tx_data_o,
    output logic                      tx_valid_o,
    input  logic                      tx_ready_i,

    output spim_pkg::spim_xfer_req_t  rx_req_o,
    output logic                      rx_start_o,
    input  logic                      rx_done_i,
    input  logic [`SPIM_DATA_W-1:0]   rx_data_i,
    input  logic                      rx_valid_i,
    output logic                      rx_ready_o,

    input  logic [`SPIM_DATA_W-1:0]   pay_data_i,
    input  logic                      pay_valid_i,
    output logic                      pay_ready_o,
    output logic [`SPIM_DATA_W-1:0]   out_data_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i
);

    import spim_pkg::*;

    spim_op_t op;
    logic     op_valid;
    logic     cfg_taken;
    logic     seq_ready;

    spim_cmd_decode i_decode
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cmd_data_i  (cmd_data_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .op_o        (op),
        .op_valid_o  (op_valid),
        .cfg_taken_i (cfg_taken),
        .seq_ready_i (seq_ready)
    );

    // Both units see the same op; each takes only its own opcodes
    spim_cfg_cs i_cfg_cs
    (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .op_i               (op),
        .op_valid_i         (op_valid),
        .cfg_taken_o        (cfg_taken),
        .cfg_o              (cfg_o),
        .cfg_clkdiv_valid_o (cfg_clkdiv_valid_o),
        .cfg_clkdiv_ack_i   (cfg_clkdiv_ack_i),
        .spi_csn_o          (spi_csn_o),
        .eot_o              (eot_o)
    );

    spim_xfer_seq i_xfer_seq
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .op_i        (op),
        .op_valid_i  (op_valid),
        .seq_ready_o (seq_ready),
        .tx_req_o    (tx_req_o),
        .tx_start_o  (tx_start_o),
        .tx_done_i   (tx_done_i),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .tx_ready_i  (tx_ready_i),
        .rx_req_o    (rx_req_o),
        .rx_start_o  (rx_start_o),
        .rx_done_i   (rx_done_i),
        .rx_data_i   (rx_data_i),
        .rx_valid_i  (rx_valid_i),
        .rx_ready_o  (rx_ready_o),
        .pay_data_i  (pay_data_i),
        .pay_valid_i (pay_valid_i),
        .pay_ready_o (pay_ready_o),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== hw/spim_macros.svh ====
`ifndef SPIM_MACROS_SVH
`define SPIM_MACROS_SVH

////////////////////
// Datapath widths
////////////////////

// Command, payload and receive words
`define SPIM_DATA_W   32
// Transfer length field
`define SPIM_SIZE_W   16
`define SPIM_CLKDIV_W 8
`define SPIM_CMD_W    4

////////////////////
// Counts
////////////////////

`define SPIM_NUM_CS   4
// Wait-cycle counter, fed from command bits 7..0
`define SPIM_WAIT_W   8

`endif

// ==== hw/spim_pkg.sv ====
`include "spim_macros.svh"

package spim_pkg;

    ////////////////////
    // Opcodes
    ////////////////////

    typedef enum logic [`SPIM_CMD_W-1:0]
    {
        CMD_CFG      = 4'b0000,
        CMD_SOT      = 4'b0001,
        CMD_SEND_CMD = 4'b0010,
        CMD_TX_DATA  = 4'b0110,
        CMD_RX_DATA  = 4'b0111,
        CMD_EOT      = 4'b1001,
        CMD_WAIT_CYC = 4'b1101
    } spim_cmd_e;

    ////////////////////
    // Shared structs
    ////////////////////

    // SPI mode and divider
    typedef struct packed
    {
        logic                      cpol;
        logic                      cpha;
        logic [`SPIM_CLKDIV_W-1:0] clkdiv;
    } spim_cfg_t;

    // Request to a shift engine
    typedef struct packed
    {
        logic                    qpi;
        logic                    custom;
        logic [`SPIM_SIZE_W-1:0] size;
    } spim_xfer_req_t;

    // One decoded command
    typedef struct packed
    {
        spim_cmd_e                       cmd;
        spim_cfg_t                       cfg;
        logic [$clog2(`SPIM_NUM_CS)-1:0] cs;
        logic                            eot;
        logic                            qpi;
        logic                            custom;
        logic [`SPIM_SIZE_W-1:0]         size;
        logic [`SPIM_DATA_W/2-1:0]       cmd_data;
    } spim_op_t;

endpackage

// ==== hw/spim_xfer_seq.sv ====
`timescale 1ns/1ns
`include "spim_macros.svh"

module spim_xfer_seq
(
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  spim_pkg::spim_op_t        op_i,
    input  logic                      op_valid_i,
    output logic                      seq_ready_o,

    output spim_pkg::spim_xfer_req_t  tx_req_o,
    output logic                      tx_start_o,
    input  logic                      tx_done_i,
    output logic [`SPIM_DATA_W-1:0]   tx_data_o,
    output logic                      tx_valid_o,
    input  logic                      tx_ready_i,

    output spim_pkg::spim_xfer_req_t  rx_req_o,
    output logic                      rx_start_o,
    input  logic                      rx_done_i,
    input  logic [`SPIM_DATA_W-1:0]   rx_data_i,
    input  logic                      rx_valid_i,
    output logic                      rx_ready_o,

    input  logic [`SPIM_DATA_W-1:0]   pay_data_i,
    input  logic                      pay_valid_i,
    output logic                      pay_ready_o,
    output logic [`SPIM_DATA_W-1:0]   out_data_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i
);

    import spim_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_CMD, S_TX, S_RX, S_WAIT} seq_state_e;

    seq_state_e                  state_q;
    seq_state_e                  state_d;
    logic                        op_take;
    logic                        tx_start_q;
    logic                        rx_start_q;
    logic                        word_pend_q;
    logic [`SPIM_WAIT_W-1:0]     wait_cnt_q;
    spim_xfer_req_t              req_q;
    logic [`SPIM_DATA_W/2-1:0]   cmd_word_q;

    assign seq_ready_o = (state_q == S_IDLE);
    assign op_take     = op_valid_i && seq_ready_o &&
                         (op_i.cmd inside {CMD_SEND_CMD, CMD_TX_DATA, CMD_RX_DATA, CMD_WAIT_CYC});

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:
            begin
                if (op_take)
                begin
                    case (op_i.cmd)
                        CMD_SEND_CMD: state_d = S_CMD;
                        CMD_TX_DATA:  state_d = S_TX;
                        CMD_RX_DATA:  state_d = S_RX;
                        default:      state_d = S_WAIT;
                    endcase
                end
            end
            S_CMD, S_TX:
                if (tx_done_i)
                    state_d = S_IDLE;
            S_RX:
                if (rx_done_i)
                    state_d = S_IDLE;
            S_WAIT:
                if (wait_cnt_q == '0)
                    state_d = S_IDLE;
            default:
                state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q     <= S_IDLE;
            tx_start_q  <= 1'b0;
            rx_start_q  <= 1'b0;
            word_pend_q <= 1'b0;
            wait_cnt_q  <= '0;
        end
        else
        begin
            state_q    <= state_d;
            tx_start_q <= op_take && (op_i.cmd inside {CMD_SEND_CMD, CMD_TX_DATA});
            rx_start_q <= op_take && (op_i.cmd == CMD_RX_DATA);

            if (op_take)
                word_pend_q <= (op_i.cmd == CMD_SEND_CMD);
            else if (state_q == S_CMD && tx_ready_i)
                word_pend_q <= 1'b0;

            // Counts N down to zero, giving N+1 busy cycles
            if (op_take)
                wait_cnt_q <= op_i.cmd_data[`SPIM_WAIT_W-1:0];
            else if (state_q == S_WAIT && wait_cnt_q != '0)
                wait_cnt_q <= wait_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (op_take)
        begin
            req_q.qpi    <= op_i.qpi;
            req_q.custom <= (op_i.cmd == CMD_SEND_CMD) ? 1'b1 : op_i.custom;
            req_q.size   <= op_i.size;
            cmd_word_q   <= op_i.cmd_data;
        end
    end

    ////////////////////
    // Stream routing
    ////////////////////

    always_comb
    begin
        tx_data_o   = pay_data_i;
        tx_valid_o  = 1'b0;
        pay_ready_o = 1'b0;
        out_data_o  = rx_data_i;
        out_valid_o = 1'b0;
        rx_ready_o  = 1'b0;
        case (state_q)
            S_CMD:
            begin
                tx_data_o  = {cmd_word_q, {(`SPIM_DATA_W/2){1'b0}}};
                tx_valid_o = word_pend_q;
            end
            S_TX:
            begin
                tx_valid_o  = pay_valid_i;
                pay_ready_o = tx_ready_i;
            end
            S_RX:
            begin
                out_valid_o = rx_valid_i;
                rx_ready_o  = out_ready_i;
            end
            default:
            begin
            end
        endcase
    end

    assign tx_req_o   = req_q;
    assign rx_req_o   = req_q;
    assign tx_start_o = tx_start_q;
    assign rx_start_o = rx_start_q;

    a_one_start: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(tx_start_o && rx_start_o));

endmodule

// ==== verif/spim_tests.txt ====
// Columns (hex): kind cmd exp0 exp1 nwords, then nwords data words; a lone 0 ends the list
// Kinds: 1 CFG, 2 SOT, 3 EOT, 4 SEND_CMD, 5 TX_DATA, 6 RX_DATA, 7 WAIT_CYC with queued command

// CFG: exp0 is the expected cfg struct
1 00000305 00000305 00000000 0
1 00000114 00000114 00000000 0

// SOT: exp0 is the chip-select vector; EOT adds the eot flag in exp1
2 10000002 0000000b 00000000 0
3 90000001 0000000f 00000001 0
2 10000000 0000000e 00000000 0
3 90000000 0000000f 00000000 0
2 10000003 00000007 00000000 0

// SEND_CMD: exp0 is the request, the one data word is the tx word
4 280fa55a 0003000f 00000000 1 a55a0000
4 20071234 00010007 00000000 1 12340000

// TX_DATA: payload words, expected on tx_data_o in the same order
5 64000003 00010003 00000000 3 11111111 22222222 33333333
5 68000005 00020005 00000000 5 0badf00d 5a5a5a5a a5a5a5a5 ffffffff 00000001

// RX_DATA: engine words, expected on out_data_o in the same order
6 74000004 00010004 00000000 4 c0de0001 c0de0002 c0de0003 c0de0004
6 7c000006 00030006 00000000 6 00000000 ffffffff 12345678 87654321 deadbeef 0000abcd

// WAIT_CYC: exp0 is N+1 quiet cycles, exp1 the queued SEND_CMD, data its tx word
7 d0000005 00000006 20030bee 1 0bee0000
7 d0000000 00000001 2001cafe 1 cafe0000

3 90000001 0000000f 00000001 0
0

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen
(
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 3;

    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial
    begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

// ==== verif/tb_spim_top.sv ====
`timescale 1ns/1ns
`include "spim_macros.svh"

module tb_spim_top;

    import spim_pkg::*;

    localparam int TIMEOUT   = 200;
    localparam int MEM_DEPTH = 256;

    // Vector kinds in the test file
    localparam int K_CFG  = 1;
    localparam int K_SOT  = 2;
    localparam int K_EOT  = 3;
    localparam int K_SEND = 4;
    localparam int K_TX   = 5;
    localparam int K_RX   = 6;
    localparam int K_WAIT = 7;

    logic                    clk;
    logic                    rstn;
    logic [`SPIM_DATA_W-1:0] cmd_data;
    logic                    cmd_valid;
    logic                    cmd_ready;
    spim_cfg_t               cfg;
    logic                    clkdiv_valid;
    logic                    clkdiv_ack;
    logic [`SPIM_NUM_CS-1:0] csn;
    logic                    eot;
    spim_xfer_req_t          tx_req;
    logic                    tx_start;
    logic                    tx_done;
    logic [`SPIM_DATA_W-1:0] tx_data;
    logic                    tx_valid;
    logic                    tx_ready;
    spim_xfer_req_t          rx_req;
    logic                    rx_start;
    logic                    rx_done;
    logic [`SPIM_DATA_W-1:0] rx_data;
    logic                    rx_valid;
    logic                    rx_ready;
    logic [`SPIM_DATA_W-1:0] pay_data;
    logic                    pay_valid;
    logic                    pay_ready;
    logic [`SPIM_DATA_W-1:0] out_data;
    logic                    out_valid;
    logic                    out_ready;

    logic [`SPIM_DATA_W-1:0] vec_mem [0:MEM_DEPTH-1];
    logic [7:0]              lfsr_state;

    tb_clk_gen i_clk_gen
    (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    spim_ctrl_top dut0
    (
        .clk_i              (clk),
        .rstn_i             (rstn),
        .cmd_data_i         (cmd_data),
        .cmd_valid_i        (cmd_valid),
        .cmd_ready_o        (cmd_ready),
        .cfg_o              (cfg),
        .cfg_clkdiv_valid_o (clkdiv_valid),
        .cfg_clkdiv_ack_i   (clkdiv_ack),
        .spi_csn_o          (csn),
        .eot_o              (eot),
        .tx_req_o           (tx_req),
        .tx_start_o         (tx_start),
        .tx_done_i          (tx_done),
        .tx_data_o          (tx_data),
        .tx_valid_o         (tx_valid),
        .tx_ready_i         (tx_ready),
        .rx_req_o           (rx_req),
        .rx_start_o         (rx_start),
        .rx_done_i          (rx_done),
        .rx_data_i          (rx_data),
        .rx_valid_i         (rx_valid),
        .rx_ready_o         (rx_ready),
        .pay_data_i         (pay_data),
        .pay_valid_i        (pay_valid),
        .pay_ready_o        (pay_ready),
        .out_data_o         (out_data),
        .out_valid_o        (out_valid),
        .out_ready_i        (out_ready)
    );

    ////////////////////
    // Failure handling
    ////////////////////

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic timeout_fail(input string sig);
        $display("Timeout while waiting for %s at %0t ns", sig, $time);
        stop_run();
    endtask

    task automatic check_cfg(input spim_cfg_t got, input spim_cfg_t exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_req(input spim_xfer_req_t got, input spim_xfer_req_t exp,
                             input string what);
        if (got !== exp)
        begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input logic [`SPIM_DATA_W-1:0] got,
                              input logic [`SPIM_DATA_W-1:0] exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cs(input logic [`SPIM_NUM_CS-1:0] got,
                            input logic [`SPIM_NUM_CS-1:0] exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    ////////////////////
    // Cycle helpers
    ////////////////////

    // Taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic random_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | lfsr_state[0];
        end
    endtask

    // Inputs change on the falling edge; single-cycle pulses drop here
    task automatic next_cycle();
        @(negedge clk);
        cmd_valid  = 1'b0;
        clkdiv_ack = 1'b0;
        tx_done    = 1'b0;
        rx_done    = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            next_cycle();
            #1;
        end
    endtask

    task automatic push_cmd(input logic [`SPIM_DATA_W-1:0] word, output int tries);
        logic accepted;
        accepted = 1'b0;
        tries    = 0;
        while (!accepted)
        begin
            if (tries == TIMEOUT)
                timeout_fail("cmd_ready_o");
            next_cycle();
            cmd_data  = word;
            cmd_valid = 1'b1;
            #1;
            accepted = cmd_ready;
            tries++;
        end
    endtask

    task automatic wait_start(input logic rx_side, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen)
        begin
            if (cycles == TIMEOUT)
                timeout_fail(rx_side ? "rx_start_o" : "tx_start_o");
            next_cycle();
            #1;
            cycles++;
            seen = rx_side ? rx_start : tx_start;
        end
    endtask

    ////////////////////
    // Engine models
    ////////////////////

    task automatic run_tx(input int first, input int count, input logic with_payload);
        int taken;
        int cycles;
        int delay;
        int bit_val;
        taken  = 0;
        cycles = 0;
        while (taken < count)
        begin
            if (cycles == TIMEOUT)
                timeout_fail("tx_valid_o");
            next_cycle();
            random_bits(1, bit_val);
            tx_ready  = bit_val[0];
            pay_valid = with_payload;
            if (with_payload)
                pay_data = vec_mem[first + taken];
            #1;
            check_flag(tx_start, 1'b0, "tx_start_o before tx_done_i");
            if (with_payload)
                check_flag(pay_ready, tx_ready, "pay_ready_o");
            if (tx_valid && tx_ready)
            begin
                check_word(tx_data, vec_mem[first + taken], "tx_data_o");
                taken++;
            end
            cycles++;
        end
        random_bits(3, delay);
        repeat (delay + 1)
        begin
            next_cycle();
            pay_valid = 1'b0;
            #1;
            check_flag(tx_valid, 1'b0, "tx_valid_o after last word");
            check_flag(tx_start, 1'b0, "tx_start_o before tx_done_i");
        end
        next_cycle();
        tx_done  = 1'b1;
        tx_ready = 1'b0;
        #1;
    endtask

    task automatic run_rx(input int first, input int count);
        int sent;
        int seen;
        int cycles;
        int delay;
        int bit_val;
        sent   = 0;
        seen   = 0;
        cycles = 0;
        while (seen < count)
        begin
            if (cycles == TIMEOUT)
                timeout_fail("out_valid_o");
            next_cycle();
            rx_valid = (sent < count);
            if (sent < count)
                rx_data = vec_mem[first + sent];
            random_bits(1, bit_val);
            out_ready = bit_val[0];
            #1;
            check_flag(rx_ready, out_ready, "rx_ready_o");
            check_flag(rx_start, 1'b0, "rx_start_o before rx_done_i");
            if (out_valid && out_ready)
            begin
                check_word(out_data, vec_mem[first + seen], "out_data_o");
                seen++;
            end
            if (rx_valid && rx_ready)
                sent++;
            cycles++;
        end
        check_flag(sent == seen, 1'b1, "rx words equal to out words");
        random_bits(3, delay);
        repeat (delay + 1)
        begin
            next_cycle();
            rx_valid  = 1'b0;
            out_ready = 1'b1;
            #1;
            check_flag(out_valid, 1'b0, "out_valid_o after last word");
        end
        next_cycle();
        rx_done = 1'b1;
        #1;
    endtask

    ////////////////////
    // Vector execution
    ////////////////////

    task automatic run_vector(input int base);
        logic [`SPIM_DATA_W-1:0] kind;
        logic [`SPIM_DATA_W-1:0] exp0;
        logic [`SPIM_DATA_W-1:0] exp1;
        int                      n;
        int                      tries;
        int                      gap;
        int                      delay;
        kind = vec_mem[base];
        exp0 = vec_mem[base + 2];
        exp1 = vec_mem[base + 3];
        n    = int'(vec_mem[base + 4]);
        push_cmd(vec_mem[base + 1], tries);
        case (int'(kind))
            K_CFG:
            begin
                wait_cycles(2);
                check_cfg(cfg, spim_cfg_t'(exp0[$bits(spim_cfg_t)-1:0]), "cfg_o");
                check_flag(clkdiv_valid, 1'b1, "cfg_clkdiv_valid_o");
                random_bits(3, delay);
                repeat (delay)
                begin
                    wait_cycles(1);
                    check_flag(clkdiv_valid, 1'b1, "cfg_clkdiv_valid_o before ack");
                end
                next_cycle();
                clkdiv_ack = 1'b1;
                #1;
                wait_cycles(1);
                check_flag(clkdiv_valid, 1'b0, "cfg_clkdiv_valid_o after ack");
            end
            K_SOT:
            begin
                wait_cycles(2);
                check_cs(csn, exp0[`SPIM_NUM_CS-1:0], "spi_csn_o");
            end
            K_EOT:
            begin
                wait_cycles(1);
                check_flag(eot, 1'b0, "eot_o one cycle after acceptance");
                wait_cycles(1);
                check_cs(csn, exp0[`SPIM_NUM_CS-1:0], "spi_csn_o");
                check_flag(eot, exp1[0], "eot_o");
                wait_cycles(1);
                check_flag(eot, 1'b0, "eot_o one cycle later");
            end
            K_SEND:
            begin
                wait_start(1'b0, gap);
                check_req(tx_req, spim_xfer_req_t'(exp0[$bits(spim_xfer_req_t)-1:0]),
                          "tx_req_o");
                check_flag(tx_valid, 1'b1, "tx_valid_o with start");
                run_tx(base + 5, n, 1'b0);
            end
            K_TX:
            begin
                wait_start(1'b0, gap);
                check_req(tx_req, spim_xfer_req_t'(exp0[$bits(spim_xfer_req_t)-1:0]),
                          "tx_req_o");
                run_tx(base + 5, n, 1'b1);
            end
            K_RX:
            begin
                wait_start(1'b1, gap);
                check_req(rx_req, spim_xfer_req_t'(exp0[$bits(spim_xfer_req_t)-1:0]),
                          "rx_req_o");
                run_rx(base + 5, n);
            end
            K_WAIT:
            begin
                // Queued command goes in on the edge that consumes the wait op
                push_cmd(exp1, tries);
                check_flag(tries == 1, 1'b1, "queued command accepted at once");
                wait_start(1'b0, gap);
                check_flag((gap - 1) > int'(exp0), 1'b1, "quiet cycles after WAIT_CYC");
                check_flag(tx_valid, 1'b1, "tx_valid_o with start");
                run_tx(base + 5, n, 1'b0);
            end
            default:
            begin
                $display("Unknown vector kind %0d at word %0d of the test file", kind, base);
                stop_run();
            end
        endcase
    endtask

    task automatic run_all_vectors();
        int   idx;
        logic finished;
        idx      = 0;
        finished = 1'b0;
        while (!finished)
        begin
            if (idx > MEM_DEPTH - 5 || $isunknown(vec_mem[idx]))
            begin
                $display("Test file has no end record before word %0d", idx);
                stop_run();
            end
            else if (vec_mem[idx] == '0)
                finished = 1'b1;
            else
            begin
                run_vector(idx);
                idx = idx + 5 + int'(vec_mem[idx + 4]);
            end
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rstn !== 1'b1)
        begin
            if (cycles == TIMEOUT)
                timeout_fail("rstn_i release");
            @(negedge clk);
            cycles++;
        end
        wait_cycles(1);
    endtask

    initial
    begin
        cmd_data   = '0;
        cmd_valid  = 1'b0;
        clkdiv_ack = 1'b0;
        tx_done    = 1'b0;
        tx_ready   = 1'b0;
        rx_done    = 1'b0;
        rx_data    = '0;
        rx_valid   = 1'b0;
        pay_data   = '0;
        pay_valid  = 1'b0;
        out_ready  = 1'b1;
        lfsr_state = 8'd82;

        $readmemh("verif/spim_tests.txt", vec_mem);
        if ($isunknown(vec_mem[0]))
        begin
            $display("No test vectors read from verif/spim_tests.txt");
            stop_run();
        end

        wait_reset_release();
        check_flag(cmd_ready, 1'b1, "cmd_ready_o after reset");
        check_cs(csn, '1, "spi_csn_o after reset");
        check_cfg(cfg, '0, "cfg_o after reset");
        check_flag(clkdiv_valid, 1'b0, "cfg_clkdiv_valid_o after reset");
        check_flag(eot, 1'b0, "eot_o after reset");
        check_flag(tx_start, 1'b0, "tx_start_o after reset");
        check_flag(rx_start, 1'b0, "rx_start_o after reset");

        run_all_vectors();

        $display("TEST PASS");
        $finish;
    end

endmodule
